//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_approx_mult
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/approx_mult8.sv
`timescale 1ns/1ps

module approx_mult8 (
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    output logic [15:0] p
);

    logic [3:0]  a_h, a_l;
    logic [3:0]  b_h, b_l;
    logic [7:0]  p1, p2, p3, p4;
    logic [11:0] operand1;
    logic [8:0]  operand2;
    logic [12:0] out;

    assign a_h = a[7:4];
    assign a_l = a[3:0];
    assign b_h = b[7:4];
    assign b_l = b[3:0];

    assign p1 = a_h * b_h;  // Exact high partial products
    assign p2 = a_h * b_l;

    rr_4x4_3 u_m3 (.a(a_l), .b(b_h), .p(p3));
    rr_4x4_8 u_m4 (.a(a_l), .b(b_l), .p(p4));

    loa_adder #(.WIDTH(8), .OR_BITS(0)) u_add1 (.a(p2), .b(p3), .sum(operand2));

    assign operand1 = {p1, p4[7:4]};

    loa_adder #(.WIDTH(12), .OR_BITS(3)) u_add2 (
        .a  (operand1),
        .b  ({3'b000, operand2}),
        .sum(out)
    );

    assign p = {out[11:0], p4[3:0]};  // Low nibble of P4 passes straight through

endmodule

// 4x4 split as 3+1 bits
module rr_4x4_3 (
    input  logic [3:0] a,
    input  logic [3:0] b,
    output logic [7:0] p
);

    logic [2:0] a_h, b_h;
    logic       a_l, b_l;
    logic [5:0] p1;
    logic [2:0] p2, p3;
    logic       p4;
    logic [6:0] operand1;
    logic [3:0] operand2;
    logic [7:0] out;

    assign a_h = a[3:1];
    assign b_h = b[3:1];
    assign a_l = a[0];
    assign b_l = b[0];

    assign p1 = a_h * b_h;
    assign p2 = a_h * b_l;
    assign p3 = a_l * b_h;
    assign p4 = a_l & b_l;

    loa_adder #(.WIDTH(3), .OR_BITS(0)) u_add1 (.a(p2), .b(p3), .sum(operand2));

    assign operand1 = {p1, 1'b0};

    loa_adder #(.WIDTH(7), .OR_BITS(3)) u_add2 (
        .a  (operand1),
        .b  ({3'b000, operand2}),
        .sum(out)
    );

    assign p = {out[6:0], p4};

endmodule

// 4x4 split as 2+2 bits
module rr_4x4_8 (
    input  logic [3:0] a,
    input  logic [3:0] b,
    output logic [7:0] p
);

    logic [1:0] a_h, a_l;
    logic [1:0] b_h, b_l;
    logic [3:0] p1, p2, p3, p4;
    logic [5:0] operand1;
    logic [4:0] operand2;
    logic [6:0] out;

    assign a_h = a[3:2];
    assign a_l = a[1:0];
    assign b_h = b[3:2];
    assign b_l = b[1:0];

    assign p1 = a_h * b_h;
    assign p2 = a_h * b_l;
    assign p3 = a_l * b_h;
    assign p4 = a_l * b_l;

    loa_adder #(.WIDTH(4), .OR_BITS(0)) u_add1 (.a(p2), .b(p3), .sum(operand2));

    assign operand1 = {p1, p4[3:2]};

    loa_adder #(.WIDTH(6), .OR_BITS(1)) u_add2 (
        .a  (operand1),
        .b  ({1'b0, operand2}),
        .sum(out)
    );

    assign p = {out[5:0], p4[1:0]};

endmodule

//--- design/approx_mult_top.sv
`timescale 1ns/1ps

module approx_mult_top (
    input  logic                clk,
    input  logic                rst_n,
    input  axil_pkg::axil_req_t req,
    output axil_pkg::axil_rsp_t rsp
);

    import mult_pkg::*;

    mult_cmd_t cmd;
    logic      cmd_valid;
    stage_t    stage;
    mult_res_t res;

    mult_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .rsp      (rsp),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .res      (res)
    );

    mult_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .stage_out(stage)
    );

    mult_result u_result (
        .clk     (clk),
        .rst_n   (rst_n),
        .stage_in(stage),
        .res     (res)
    );

endmodule

//--- design/axil_pkg.sv
package axil_pkg;

    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;

    localparam logic [ADDR_W-1:0] REG_CMD     = 4'h0;
    localparam logic [ADDR_W-1:0] REG_PRODUCT = 4'h4;
    localparam logic [ADDR_W-1:0] REG_ERROR   = 4'h8;
    localparam logic [ADDR_W-1:0] REG_COUNT   = 4'hC;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // Master side of the bus
    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [DATA_W-1:0] wdata;
        logic              wvalid;
        logic              bready;
        logic [ADDR_W-1:0] araddr;
        logic              arvalid;
        logic              rready;
    } axil_req_t;

    // Slave side of the bus
    typedef struct packed {
        logic              awready;
        logic              wready;
        resp_e             bresp;
        logic              bvalid;
        logic              arready;
        logic [DATA_W-1:0] rdata;
        resp_e             rresp;
        logic              rvalid;
    } axil_rsp_t;

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

endpackage

//--- design/loa_adder.sv
`timescale 1ns/1ps

module loa_adder #(
    parameter int WIDTH   = 8,
    parameter int OR_BITS = 0
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH:0]   sum
);

    generate
        if (OR_BITS == 0) begin : g_exact
            assign sum = a + b;  // Top bit is the carry out
        end else begin : g_loa
            logic [WIDTH-OR_BITS:0] upper;
            logic [OR_BITS-1:0]     lower;

            // No carry from the OR part into the upper part
            assign upper = a[WIDTH-1:OR_BITS] + b[WIDTH-1:OR_BITS];
            assign lower = a[OR_BITS-1:0] | b[OR_BITS-1:0];
            assign sum   = {upper, lower};
        end
    endgenerate

endmodule

//--- design/mult_decode.sv
`timescale 1ns/1ps

module mult_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  axil_pkg::axil_req_t req,
    output axil_pkg::axil_rsp_t rsp,
    output mult_pkg::mult_cmd_t cmd,
    output logic                cmd_valid,
    input  mult_pkg::mult_res_t res
);

    import axil_pkg::*;
    import mult_pkg::*;

    wr_state_e         wr_state;
    rd_state_e         rd_state;
    logic              wr_accept;
    logic              rd_accept;
    logic              cmd_hit;
    resp_e             bresp;
    resp_e             rresp;
    resp_e             rresp_next;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] rdata_next;

    // AW and W are taken together
    assign wr_accept = (wr_state == WR_IDLE) && req.awvalid && req.wvalid;
    assign rd_accept = (rd_state == RD_IDLE) && req.arvalid;
    assign cmd_hit   = (req.awaddr == REG_CMD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state  <= WR_IDLE;
            bresp     <= RESP_OKAY;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;  // Single-cycle pulse
            case (wr_state)
                WR_IDLE: begin
                    if (wr_accept) begin
                        wr_state  <= WR_RESP;
                        bresp     <= cmd_hit ? RESP_OKAY : RESP_SLVERR;
                        cmd_valid <= cmd_hit;
                    end
                end
                WR_RESP: begin
                    if (req.bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept && cmd_hit) begin
            cmd.a    <= req.wdata[7:0];
            cmd.b    <= req.wdata[15:8];
            cmd.mode <= mode_e'(req.wdata[16]);
        end
    end

    always_comb begin
        rdata_next = '0;
        rresp_next = RESP_OKAY;
        case (req.araddr)
            REG_PRODUCT: rdata_next = DATA_W'(res.product);
            REG_ERROR:   rdata_next = DATA_W'(res.error);
            REG_COUNT:   rdata_next = DATA_W'(res.done_count);
            default:     rresp_next = RESP_SLVERR;  // REG_CMD is write-only
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
        end else if (rd_accept) begin
            rd_state <= RD_DATA;
        end else if (rd_state == RD_DATA && req.rready) begin
            rd_state <= RD_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rdata_next;  // Held stable until RREADY
            rresp <= rresp_next;
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = wr_accept;
        rsp.wready  = wr_accept;
        rsp.bvalid  = (wr_state == WR_RESP);
        rsp.bresp   = bresp;
        rsp.arready = (rd_state == RD_IDLE);
        rsp.rvalid  = (rd_state == RD_DATA);
        rsp.rdata   = rdata;
        rsp.rresp   = rresp;
    end

endmodule

//--- design/mult_execute.sv
`timescale 1ns/1ps

module mult_execute (
    input  logic                clk,
    input  logic                rst_n,
    input  mult_pkg::mult_cmd_t cmd,
    input  logic                cmd_valid,
    output mult_pkg::stage_t    stage_out
);

    import mult_pkg::*;

    mult_cmd_t            s1_cmd;
    logic                 s1_valid;
    logic [PRODUCT_W-1:0] approx_p;
    logic                 s2_valid;
    mode_e                s2_mode;
    logic [PRODUCT_W-1:0] s2_exact;
    logic [PRODUCT_W-1:0] s2_approx;

    approx_mult8 u_approx (
        .a(s1_cmd.a),
        .b(s1_cmd.b),
        .p(approx_p)
    );

    // Each stage carries its own valid so two commands can be in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= cmd_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_cmd    <= cmd;
        s2_mode   <= s1_cmd.mode;
        s2_exact  <= s1_cmd.a * s1_cmd.b;
        s2_approx <= approx_p;
    end

    assign stage_out = '{valid: s2_valid, mode: s2_mode, exact: s2_exact, approx: s2_approx};

endmodule

//--- design/mult_pkg.sv
package mult_pkg;

    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 2 * OPERAND_W;
    localparam int COUNT_W   = 16;

    // Selects which product the host reads back
    typedef enum logic {
        MODE_EXACT  = 1'b0,
        MODE_APPROX = 1'b1
    } mode_e;

    // Field order matches the REG_CMD data layout
    typedef struct packed {
        mode_e                mode;  // Bit 16
        logic [OPERAND_W-1:0] b;     // Bits 15:8
        logic [OPERAND_W-1:0] a;     // Bits 7:0
    } mult_cmd_t;

    typedef struct packed {
        logic [PRODUCT_W-1:0] product;
        logic [PRODUCT_W-1:0] error;
        logic [COUNT_W-1:0]   done_count;
    } mult_res_t;

    typedef struct packed {
        logic                 valid;
        mode_e                mode;
        logic [PRODUCT_W-1:0] exact;
        logic [PRODUCT_W-1:0] approx;
    } stage_t;

endpackage

//--- design/mult_result.sv
`timescale 1ns/1ps

module mult_result (
    input  logic                clk,
    input  logic                rst_n,
    input  mult_pkg::stage_t    stage_in,
    output mult_pkg::mult_res_t res
);

    import mult_pkg::*;

    logic [PRODUCT_W-1:0] product_sel;
    logic [PRODUCT_W-1:0] error_dist;

    assign product_sel = (stage_in.mode == MODE_EXACT) ? stage_in.exact : stage_in.approx;

    // LOA only ever loses value, so this never goes negative
    assign error_dist = stage_in.exact - stage_in.approx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res <= '0;
        end else if (stage_in.valid) begin
            res.product    <= product_sel;
            res.error      <= error_dist;
            res.done_count <= res.done_count + 1'b1;  // Wraps
        end
    end

endmodule

//--- list.f
design/mult_pkg.sv
design/axil_pkg.sv
design/loa_adder.sv
design/approx_mult8.sv
design/mult_decode.sv
design/mult_execute.sv
design/mult_result.sv
design/approx_mult_top.sv
test/mult_properties.sv
test/tb_approx_mult.sv

//--- test/mult_properties.sv
`timescale 1ns/1ps

module mult_properties (
    input logic                clk,
    input logic                rst_n,
    input axil_pkg::axil_req_t req,
    input axil_pkg::axil_rsp_t rsp,
    input mult_pkg::stage_t    stage
);

    int fail_count = 0;

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.bvalid && !req.bready) |=> rsp.bvalid)
        else begin
            $error("BVALID dropped before BREADY was seen");
            fail_count++;
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.rvalid && !req.rready) |=> (rsp.rvalid && $stable(rsp.rdata)))
        else begin
            $error("RVALID dropped or RDATA changed before RREADY was seen");
            fail_count++;
        end

    // LOA only loses value, so the stage 2 approximation stays at or below exact
    approx_bound: assert property (@(posedge clk) disable iff (!rst_n)
        stage.valid |-> (stage.approx <= stage.exact))
        else begin
            $error("Approximate product exceeds exact product in stage 2");
            fail_count++;
        end

    reset_idle: assert property (@(posedge clk)
        !rst_n |=> (!rsp.bvalid && !rsp.rvalid))
        else begin
            $error("BVALID or RVALID high after reset");
            fail_count++;
        end

endmodule

//--- test/tb_approx_mult.sv
`timescale 1ns/1ps

module tb_approx_mult;

    import axil_pkg::*;
    import mult_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_RANDOM   = 200;
    localparam int N_PAIRS    = N_RANDOM + 9;
    localparam int N_BUS_OPS  = N_PAIRS * 2 * 4 + 40;  // Write plus three reads per command
    localparam int TIMEOUT_NS = N_BUS_OPS * 20 * CLK_PERIOD + 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    axil_req_t   req;
    axil_rsp_t   rsp;
    logic [7:0]  corners [3] = '{8'h00, 8'h01, 8'hFF};
    logic [7:0]  pair_a[$];
    logic [7:0]  pair_b[$];
    logic [15:0] exp_count = '0;
    logic [15:0] exp_product = '0;
    logic [15:0] exp_error = '0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    approx_mult_top UUT (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp));

    bind approx_mult_top mult_properties u_props (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .rsp  (rsp),
        .stage(stage)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Low k bits ORed, upper parts added exactly with the carry kept
    function automatic int loa_sum(input int x, input int y, input int k);
        int low_mask;
        low_mask = (1 << k) - 1;
        return (((x >> k) + (y >> k)) << k) | ((x | y) & low_mask);
    endfunction

    function automatic int rr_3_1_product(input int a, input int b);
        int cross_sum;
        int out;
        cross_sum = (a >> 1) * (b & 1) + (a & 1) * (b >> 1);
        out       = loa_sum(((a >> 1) * (b >> 1)) << 1, cross_sum, 3);
        return ((out & 'h7F) << 1) | ((a & 1) * (b & 1));
    endfunction

    function automatic int rr_2_2_product(input int a, input int b);
        int low;
        int cross_sum;
        int out;
        low       = (a & 3) * (b & 3);
        cross_sum = (a >> 2) * (b & 3) + (a & 3) * (b >> 2);
        out       = loa_sum((((a >> 2) * (b >> 2)) << 2) | (low >> 2), cross_sum, 1);
        return ((out & 'h3F) << 2) | (low & 3);
    endfunction

    function automatic int approx_product(input int a, input int b);
        int p4;
        int cross_sum;
        int out;
        p4        = rr_2_2_product(a & 'hF, b & 'hF);
        cross_sum = (a >> 4) * (b & 'hF) + rr_3_1_product(a & 'hF, b >> 4);
        out       = loa_sum((((a >> 4) * (b >> 4)) << 4) | (p4 >> 4), cross_sum, 3);
        return ((out & 'hFFF) << 4) | (p4 & 'hF);
    endfunction

    // Called on a rising edge, so a new write can follow the last one directly
    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input int stall, output resp_e resp);
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= data;
        req.wvalid  <= 1'b1;
        do @(negedge clk); while (!(rsp.awready && rsp.wready));
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        repeat (stall) @(posedge clk);  // BREADY held low
        req.bready <= 1'b1;
        do @(negedge clk); while (!rsp.bvalid);
        resp = rsp.bresp;
        @(posedge clk);
        req.bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, input int stall,
                            output logic [DATA_W-1:0] data, output resp_e resp);
        @(posedge clk);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        do @(negedge clk); while (!rsp.arready);
        @(posedge clk);
        req.arvalid <= 1'b0;
        repeat (stall) @(posedge clk);  // RREADY held low
        req.rready <= 1'b1;
        do @(negedge clk); while (!rsp.rvalid);
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        req.rready <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        assert (actual === expected)
        else begin
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_check(input string name, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] expected, input resp_e exp_resp,
                              input int stall);
        logic [DATA_W-1:0] data;
        resp_e             resp;
        read_reg(addr, stall, data, resp);
        check_value(name, expected, data);
        check_value({name, " RRESP"}, DATA_W'(exp_resp), DATA_W'(resp));
    endtask

    task automatic write_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input resp_e exp_resp, input int stall);
        resp_e resp;
        write_reg(addr, data, stall, resp);
        check_value("BRESP", DATA_W'(exp_resp), DATA_W'(resp));
    endtask

    task automatic issue_cmd(input logic [7:0] a, input logic [7:0] b, input mode_e mode,
                             input int stall);
        int exact;
        int approx;
        exact  = a * b;
        approx = approx_product(a, b);
        write_check(REG_CMD, {15'd0, mode, b, a}, RESP_OKAY, stall);
        exp_count   = exp_count + 16'd1;
        exp_product = (mode == MODE_EXACT) ? 16'(exact) : 16'(approx);
        exp_error   = 16'(exact - approx);
    endtask

    task automatic check_results(input int stall);
        repeat (4) @(posedge clk);  // Pipeline plus result register
        read_check("PRODUCT", REG_PRODUCT, DATA_W'(exp_product), RESP_OKAY, stall);
        read_check("ERROR", REG_ERROR, DATA_W'(exp_error), RESP_OKAY, stall);
        read_check("COUNT", REG_COUNT, DATA_W'(exp_count), RESP_OKAY, stall);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, a bus handshake never completed", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int errs_before;
        void'($urandom(26));
        rst_n = 1'b0;
        req   = '0;
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                pair_a.push_back(corners[i]);
                pair_b.push_back(corners[j]);
            end
        end
        repeat (N_RANDOM) begin
            pair_a.push_back(8'($urandom));
            pair_b.push_back(8'($urandom));
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        errs_before = errors;
        read_check("PRODUCT", REG_PRODUCT, '0, RESP_OKAY, 0);
        read_check("ERROR", REG_ERROR, '0, RESP_OKAY, 1);
        read_check("COUNT", REG_COUNT, '0, RESP_OKAY, 0);
        end_test("reset values", errs_before);

        errs_before = errors;
        foreach (pair_a[i]) begin
            issue_cmd(pair_a[i], pair_b[i], MODE_EXACT, $urandom_range(0, 3));
            check_results($urandom_range(0, 3));
        end
        end_test("exact mode", errs_before);

        errs_before = errors;
        foreach (pair_a[i]) begin
            issue_cmd(pair_a[i], pair_b[i], MODE_APPROX, $urandom_range(0, 3));
            check_results($urandom_range(0, 3));
        end
        end_test("approx mode", errs_before);

        errs_before = errors;
        for (int i = 0; i < 4; i++) begin
            issue_cmd(8'($urandom), 8'($urandom), MODE_APPROX, 0);  // Several in flight
        end
        check_results(0);
        end_test("back-to-back count", errs_before);

        errs_before = errors;
        issue_cmd(8'hB7, 8'h5D, MODE_APPROX, 6);
        check_results(6);
        end_test("back-pressure", errs_before);

        errs_before = errors;
        write_check(REG_PRODUCT, 32'h0001_2345, RESP_SLVERR, 1);
        write_check(4'h2, 32'h0000_0303, RESP_SLVERR, 0);
        read_check("CMD", REG_CMD, '0, RESP_SLVERR, 2);
        read_check("UNMAPPED", 4'h6, '0, RESP_SLVERR, 0);
        check_results(1);
        end_test("unmapped access", errs_before);

        errors = errors + UUT.u_props.fail_count;  // Bound handshake and product assertions
        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
